/* verilog/soc_pkg.sv */
package soc_pkg;

    // --------------------
    // Bus types
    // --------------------
    typedef logic [31:0] wb_addr_t;
    typedef logic [31:0] wb_data_t;
    typedef logic [3:0]  wb_sel_t;

    // Master side of a classic Wishbone transfer
    typedef struct packed {
        wb_addr_t adr;
        wb_sel_t  sel;
        logic     we;
        wb_data_t dat;
        logic     cyc;
        logic     stb;
    } wb_req_t;

    // Slave side, one of ack or err per transfer
    typedef struct packed {
        wb_data_t dat;
        logic     ack;
        logic     err;
    } wb_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_M0,
        ARB_M1
    } arb_state_t;

    // Bit 0 timer, bits 2:1 external lines
    typedef logic [2:0] irq_vec_t;

    // --------------------
    // Address map
    // --------------------
    localparam int N_SLAVES  = 3;
    localparam int SLV_BOOT  = 0;
    localparam int SLV_TIMER = 1;
    localparam int SLV_IRQ   = 2;

    // Region nibble is adr[31:28]
    localparam logic [3:0] REGION_BOOT  = 4'd0;
    localparam logic [3:0] REGION_TIMER = 4'd1;
    localparam logic [3:0] REGION_IRQ   = 4'd2;

    localparam int BOOT_WORDS = 256;
    localparam int BOOT_AW    = 8;

    // Register offsets on adr[3:2]
    localparam logic [1:0] TMR_LOAD  = 2'd0;
    localparam logic [1:0] TMR_VALUE = 2'd1;
    localparam logic [1:0] TMR_CTRL  = 2'd2;
    localparam logic [1:0] TMR_CLEAR = 2'd3;

    localparam logic [1:0] IRQ_STATUS     = 2'd0;
    localparam logic [1:0] IRQ_ENABLE_SET = 2'd1;
    localparam logic [1:0] IRQ_ENABLE_CLR = 2'd2;

endpackage

/* verilog/wb_arbiter.sv */
module wb_arbiter (
    input  logic             i_clk,
    input  logic             i_rst_n,

    // Master ports
    input  soc_pkg::wb_req_t i_m0_req,
    input  soc_pkg::wb_req_t i_m1_req,
    output soc_pkg::wb_rsp_t o_m0_rsp,
    output soc_pkg::wb_rsp_t o_m1_rsp,

    // Shared bus towards the decoder
    output soc_pkg::wb_req_t o_bus_req,
    input  soc_pkg::wb_rsp_t i_bus_rsp
);

    import soc_pkg::*;

    arb_state_t state_q;
    arb_state_t state_d;

    // --------------------
    // Grant FSM
    // --------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                // Fixed priority with master 0 first
                if (i_m0_req.cyc) begin
                    state_d = ARB_M0;
                end else if (i_m1_req.cyc) begin
                    state_d = ARB_M1;
                end
            end
            ARB_M0: begin
                if (!i_m0_req.cyc) begin
                    state_d = ARB_IDLE;
                end
            end
            ARB_M1: begin
                if (!i_m1_req.cyc) begin
                    state_d = ARB_IDLE;
                end
            end
            default: state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // Request and response steering
    // --------------------
    always_comb begin
        o_bus_req = '0;
        o_m0_rsp  = '0;
        o_m1_rsp  = '0;
        case (state_q)
            ARB_M0: begin
                o_bus_req = i_m0_req;
                o_m0_rsp  = i_bus_rsp;
            end
            ARB_M1: begin
                o_bus_req = i_m1_req;
                o_m1_rsp  = i_bus_rsp;
            end
            default: ;
        endcase
    end

    // Each bus response goes to exactly one master
    a_single_master_rsp: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_bus_rsp.ack || i_bus_rsp.err) |->
            ((o_m0_rsp.ack || o_m0_rsp.err) != (o_m1_rsp.ack || o_m1_rsp.err)))
        else $error("bus response not delivered to exactly one master");

endmodule

/* verilog/wb_decoder.sv */
module wb_decoder (
    input  logic                                       i_clk,
    input  logic                                       i_rst_n,
    input  soc_pkg::wb_req_t                           i_bus_req,
    output soc_pkg::wb_rsp_t                           o_bus_rsp,
    output soc_pkg::wb_req_t [soc_pkg::N_SLAVES-1:0]   o_slv_req,
    input  soc_pkg::wb_rsp_t [soc_pkg::N_SLAVES-1:0]   i_slv_rsp
);

    import soc_pkg::*;

    logic [3:0]          region;
    logic [N_SLAVES-1:0] hit;
    logic                unmapped;
    logic                err_q;

    assign region = i_bus_req.adr[31:28];

    // Region to slave select
    assign hit[SLV_BOOT]  = (region == REGION_BOOT);
    assign hit[SLV_TIMER] = (region == REGION_TIMER);
    assign hit[SLV_IRQ]   = (region == REGION_IRQ);

    assign unmapped = i_bus_req.cyc & i_bus_req.stb & ~(|hit);

    // Only the selected slave sees cyc and stb
    always_comb begin
        for (int i = 0; i < N_SLAVES; i++) begin
            o_slv_req[i]     = i_bus_req;
            o_slv_req[i].cyc = i_bus_req.cyc & hit[i];
            o_slv_req[i].stb = i_bus_req.stb & hit[i];
        end
    end

    // Error pulse for a hole in the map, one cycle after stb
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            err_q <= 1'b0;
        end else begin
            err_q <= unmapped & ~err_q;
        end
    end

    // --------------------
    // Response mux
    // --------------------
    always_comb begin
        o_bus_rsp = '0;
        for (int i = 0; i < N_SLAVES; i++) begin
            if (hit[i]) begin
                o_bus_rsp = i_slv_rsp[i];
            end
        end
        o_bus_rsp.err = o_bus_rsp.err | err_q;
    end

    a_ack_err_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_bus_rsp.ack && o_bus_rsp.err))
        else $error("ack and err high together on the shared bus");

endmodule

/* verilog/boot_mem.sv */
module boot_mem (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  soc_pkg::wb_req_t i_req,
    output soc_pkg::wb_rsp_t o_rsp
);

    import soc_pkg::*;

    localparam int N_LANES = $bits(wb_sel_t);

    wb_data_t             mem [BOOT_WORDS];
    wb_data_t             rdat_q;
    logic                 ack_q;
    logic                 access;
    logic [BOOT_AW-1:0]   waddr;

    // New transfer only, the held stb during ack is ignored
    assign access = i_req.cyc & i_req.stb & ~ack_q;
    assign waddr  = i_req.adr[BOOT_AW+1:2];

    // Byte lane writes
    always_ff @(posedge i_clk) begin
        if (access && i_req.we) begin
            for (int b = 0; b < N_LANES; b++) begin
                if (i_req.sel[b]) begin
                    mem[waddr][8*b +: 8] <= i_req.dat[8*b +: 8];
                end
            end
        end
    end

    // Whole word read, returned with ack
    always_ff @(posedge i_clk) begin
        if (access) begin
            rdat_q <= mem[waddr];
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign o_rsp.dat = rdat_q;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;

endmodule

/* verilog/timer_module.sv */
module timer_module (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  soc_pkg::wb_req_t i_req,
    output soc_pkg::wb_rsp_t o_rsp,
    output logic             o_timer_int
);

    import soc_pkg::*;

    wb_data_t   load_q;
    wb_data_t   value_q;
    wb_data_t   rdat_q;
    logic       en_q;
    logic       periodic_q;
    logic       flag_q;
    logic       ack_q;
    logic       access;
    logic       wr;
    logic [1:0] reg_sel;
    logic       at_zero;

    assign access  = i_req.cyc & i_req.stb & ~ack_q;
    assign wr      = access & i_req.we;
    assign reg_sel = i_req.adr[3:2];
    assign at_zero = en_q & (value_q == '0);

    // --------------------
    // Counter and control
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            load_q     <= '0;
            value_q    <= '0;
            en_q       <= 1'b0;
            periodic_q <= 1'b0;
        end else begin
            if (en_q) begin
                if (value_q == '0) begin
                    // Reload or stop at zero
                    if (periodic_q) begin
                        value_q <= load_q;
                    end else begin
                        en_q <= 1'b0;
                    end
                end else begin
                    value_q <= value_q - 1'b1;
                end
            end
            // Software writes take priority over the count
            if (wr && reg_sel == TMR_LOAD) begin
                load_q  <= i_req.dat;
                value_q <= i_req.dat;
            end
            if (wr && reg_sel == TMR_CTRL) begin
                en_q       <= i_req.dat[0];
                periodic_q <= i_req.dat[1];
            end
        end
    end

    // Sticky flag, an expiry in the clear cycle is kept
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            flag_q <= 1'b0;
        end else if (at_zero) begin
            flag_q <= 1'b1;
        end else if (wr && reg_sel == TMR_CLEAR) begin
            flag_q <= 1'b0;
        end
    end

    // --------------------
    // Bus response
    // --------------------
    always_ff @(posedge i_clk) begin
        if (access) begin
            case (reg_sel)
                TMR_LOAD:  rdat_q <= load_q;
                TMR_VALUE: rdat_q <= value_q;
                TMR_CTRL:  rdat_q <= {30'd0, periodic_q, en_q};
                default:   rdat_q <= {31'd0, flag_q};
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign o_rsp.dat   = rdat_q;
    assign o_rsp.ack   = ack_q;
    assign o_rsp.err   = 1'b0;
    assign o_timer_int = flag_q;

    a_value_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        en_q |-> (value_q <= load_q))
        else $error("timer VALUE above LOAD while running");

endmodule

/* verilog/irq_controller.sv */
module irq_controller (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  soc_pkg::wb_req_t  i_req,
    output soc_pkg::wb_rsp_t  o_rsp,
    input  soc_pkg::irq_vec_t i_src,
    output logic              o_irq
);

    import soc_pkg::*;

    irq_vec_t   enable_q;
    wb_data_t   rdat_q;
    logic       ack_q;
    logic       irq_q;
    logic       access;
    logic       wr;
    logic [1:0] reg_sel;

    assign access  = i_req.cyc & i_req.stb & ~ack_q;
    assign wr      = access & i_req.we;
    assign reg_sel = i_req.adr[3:2];

    // --------------------
    // Enable mask
    // --------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            enable_q <= '0;
        end else if (wr && reg_sel == IRQ_ENABLE_SET) begin
            enable_q <= enable_q | i_req.dat[$bits(irq_vec_t)-1:0];
        end else if (wr && reg_sel == IRQ_ENABLE_CLR) begin
            enable_q <= enable_q & ~i_req.dat[$bits(irq_vec_t)-1:0];
        end
    end

    // Registered irq from enabled levels
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= |(i_src & enable_q);
        end
    end

    // --------------------
    // Bus response
    // --------------------
    always_ff @(posedge i_clk) begin
        if (access) begin
            case (reg_sel)
                IRQ_STATUS:     rdat_q <= {29'd0, i_src};
                IRQ_ENABLE_SET: rdat_q <= {29'd0, enable_q};
                IRQ_ENABLE_CLR: rdat_q <= {29'd0, enable_q};
                default:        rdat_q <= '0;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    assign o_rsp.dat = rdat_q;
    assign o_rsp.ack = ack_q;
    assign o_rsp.err = 1'b0;
    assign o_irq     = irq_q;

endmodule

/* verilog/periph_soc.sv */
module periph_soc (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  soc_pkg::wb_req_t i_m0_req,
    input  soc_pkg::wb_req_t i_m1_req,
    output soc_pkg::wb_rsp_t o_m0_rsp,
    output soc_pkg::wb_rsp_t o_m1_rsp,
    input  logic [1:0]       i_ext_int,
    output logic             o_irq
);

    import soc_pkg::*;

    wb_req_t                bus_req;
    wb_rsp_t                bus_rsp;
    wb_req_t [N_SLAVES-1:0] slv_req;
    wb_rsp_t [N_SLAVES-1:0] slv_rsp;
    logic                   timer_int;
    irq_vec_t               irq_src;

    // Timer on bit 0, external lines above it
    assign irq_src = {i_ext_int, timer_int};

    // --------------------
    // Bus fabric
    // --------------------
    wb_arbiter u_wb_arbiter (
        .i_clk      ( i_clk     ),
        .i_rst_n    ( i_rst_n   ),
        .i_m0_req   ( i_m0_req  ),
        .i_m1_req   ( i_m1_req  ),
        .o_m0_rsp   ( o_m0_rsp  ),
        .o_m1_rsp   ( o_m1_rsp  ),
        .o_bus_req  ( bus_req   ),
        .i_bus_rsp  ( bus_rsp   )
    );

    wb_decoder u_wb_decoder (
        .i_clk      ( i_clk     ),
        .i_rst_n    ( i_rst_n   ),
        .i_bus_req  ( bus_req   ),
        .o_bus_rsp  ( bus_rsp   ),
        .o_slv_req  ( slv_req   ),
        .i_slv_rsp  ( slv_rsp   )
    );

    // --------------------
    // Slaves
    // --------------------
    boot_mem u_boot_mem (
        .i_clk      ( i_clk              ),
        .i_rst_n    ( i_rst_n            ),
        .i_req      ( slv_req[SLV_BOOT]  ),
        .o_rsp      ( slv_rsp[SLV_BOOT]  )
    );

    timer_module u_timer_module (
        .i_clk       ( i_clk              ),
        .i_rst_n     ( i_rst_n            ),
        .i_req       ( slv_req[SLV_TIMER] ),
        .o_rsp       ( slv_rsp[SLV_TIMER] ),
        .o_timer_int ( timer_int          )
    );

    irq_controller u_irq_controller (
        .i_clk      ( i_clk            ),
        .i_rst_n    ( i_rst_n          ),
        .i_req      ( slv_req[SLV_IRQ] ),
        .o_rsp      ( slv_rsp[SLV_IRQ] ),
        .i_src      ( irq_src          ),
        .o_irq      ( o_irq            )
    );

endmodule

/* tb/tb_periph_soc.sv */
module tb_periph_soc;

    timeunit 1ns;
    timeprecision 100ps;

    import soc_pkg::*;

    localparam int XFER_LIMIT = 20;
    localparam int POLL_LIMIT = 50;
    localparam int TMR_PERIOD = 40;
    // Tests take well under 2000 cycles
    localparam int MAX_CYCLES = 20000;

    logic     clk = 1'b0;
    logic     rst_n;
    wb_req_t  m0_req;
    wb_req_t  m1_req;
    wb_rsp_t  m0_rsp;
    wb_rsp_t  m1_rsp;
    logic [1:0] ext_int;
    logic     irq;

    int       cycle_cnt = 0;
    int       err_cnt = 0;
    int       done_at [2];
    string    test_name;
    logic [31:0] rng;
    wb_data_t exp_mem [16];

    periph_soc uut (
        .i_clk    ( clk     ),
        .i_rst_n  ( rst_n   ),
        .i_m0_req ( m0_req  ),
        .i_m1_req ( m1_req  ),
        .o_m0_rsp ( m0_rsp  ),
        .o_m1_rsp ( m1_rsp  ),
        .i_ext_int( ext_int ),
        .o_irq    ( irq     )
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic wb_addr_t reg_addr(input logic [3:0] region, input logic [1:0] off);
        return {region, 24'd0, off, 2'b00};
    endfunction

    function automatic wb_addr_t boot_addr(input logic [7:0] word);
        return {REGION_BOOT, 18'd0, word, 2'b00};
    endfunction

    task automatic check_value(input wb_data_t expected, input wb_data_t actual);
        assert (actual === expected) else begin
            err_cnt++;
            $display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            err_cnt++;
            $display("Error in %s: %s", test_name, msg);
        end
    endtask

    task automatic set_request(input int master, input wb_req_t req);
        if (master == 0) begin
            m0_req = req;
        end else begin
            m1_req = req;
        end
    endtask

    // One classic Wishbone transfer, then one idle cycle
    task automatic bus_xfer(input int master, input logic we, input wb_addr_t adr,
                            input wb_data_t wdat, input wb_sel_t sel, output wb_rsp_t rsp);
        wb_req_t req;
        wb_rsp_t cur;
        logic    done;
        req     = '0;
        req.adr = adr;
        req.sel = sel;
        req.we  = we;
        req.dat = wdat;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        rsp     = '0;
        done    = 1'b0;
        set_request(master, req);
        for (int n = 0; n < XFER_LIMIT && !done; n++) begin
            @(posedge clk);
            #1;
            cur = (master == 0) ? m0_rsp : m1_rsp;
            if (cur.ack || cur.err) begin
                rsp = cur;
                done_at[master] = cycle_cnt;
                done = 1'b1;
            end
        end
        check_true(done, $sformatf("master %0d got no ack or err at address %h", master, adr));
        set_request(master, '0);
        @(posedge clk);
        #1;
    endtask

    task automatic wb_write(input int master, input wb_addr_t adr, input wb_data_t dat,
                            input wb_sel_t sel);
        wb_rsp_t rsp;
        bus_xfer(master, 1'b1, adr, dat, sel, rsp);
        check_true(rsp.ack && !rsp.err, $sformatf("write to %h did not end with ack", adr));
    endtask

    task automatic wb_read(input int master, input wb_addr_t adr, output wb_data_t rdat);
        wb_rsp_t rsp;
        bus_xfer(master, 1'b0, adr, '0, 4'hf, rsp);
        check_true(rsp.ack && !rsp.err, $sformatf("read from %h did not end with ack", adr));
        rdat = rsp.dat;
    endtask

    // Polls o_irq once per cycle
    task automatic wait_for_irq(input logic level, input int max_cycles, output logic seen);
        seen = 1'b0;
        for (int n = 0; n < max_cycles && !seen; n++) begin
            if (irq === level) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic test_boot_mem();
        wb_data_t rdat;
        wb_data_t bdat;
        test_name = "test_boot_mem";
        for (int i = 0; i < 16; i++) begin
            rng = xorshift(rng);
            exp_mem[i] = rng;
            wb_write(1, boot_addr(8'(i * 17)), rng, 4'hf);
        end
        for (int i = 0; i < 16; i++) begin
            wb_read(1, boot_addr(8'(i * 17)), rdat);
            check_value(exp_mem[i], rdat);
        end
        // Lane 2 only
        rng = xorshift(rng);
        bdat = rng;
        wb_write(1, boot_addr(8'd17), bdat, 4'b0100);
        exp_mem[1][23:16] = bdat[23:16];
        wb_read(0, boot_addr(8'd17), rdat);
        check_value(exp_mem[1], rdat);
    endtask

    task automatic test_unmapped();
        wb_rsp_t  rsp;
        wb_data_t rdat;
        test_name = "test_unmapped";
        bus_xfer(0, 1'b0, {4'h3, 28'h0000010}, '0, 4'hf, rsp);
        check_value(32'd1, {31'd0, rsp.err});
        check_value(32'd0, {31'd0, rsp.ack});
        wb_read(0, boot_addr(8'd0), rdat);
        check_value(exp_mem[0], rdat);
    endtask

    task automatic test_timer_oneshot();
        wb_data_t rdat;
        logic     done;
        test_name = "test_timer_oneshot";
        done = 1'b0;
        wb_write(0, reg_addr(REGION_TIMER, TMR_LOAD), TMR_PERIOD, 4'hf);
        wb_write(0, reg_addr(REGION_TIMER, TMR_CTRL), 32'h1, 4'hf);
        for (int n = 0; n < POLL_LIMIT && !done; n++) begin
            wb_read(0, reg_addr(REGION_TIMER, TMR_VALUE), rdat);
            if (rdat == 0) begin
                done = 1'b1;
            end
        end
        check_true(done, "timer VALUE never reached zero");
        wb_read(1, reg_addr(REGION_TIMER, TMR_CTRL), rdat);
        check_value(32'd0, {31'd0, rdat[0]});
        wb_read(1, reg_addr(REGION_IRQ, IRQ_STATUS), rdat);
        check_value(32'd1, {31'd0, rdat[0]});
        wb_write(1, reg_addr(REGION_TIMER, TMR_CLEAR), 32'h0, 4'hf);
        wb_read(1, reg_addr(REGION_IRQ, IRQ_STATUS), rdat);
        check_value(32'd0, {31'd0, rdat[0]});
    endtask

    task automatic test_timer_periodic();
        wb_data_t rdat;
        logic     seen;
        test_name = "test_timer_periodic";
        wb_write(0, reg_addr(REGION_IRQ, IRQ_ENABLE_SET), 32'h1, 4'hf);
        wb_read(0, reg_addr(REGION_IRQ, IRQ_ENABLE_SET), rdat);
        check_value(32'h1, rdat);
        wb_write(0, reg_addr(REGION_TIMER, TMR_LOAD), TMR_PERIOD, 4'hf);
        wb_write(0, reg_addr(REGION_TIMER, TMR_CTRL), 32'h3, 4'hf);
        wait_for_irq(1'b1, TMR_PERIOD + 10, seen);
        check_true(seen, "o_irq did not rise in the first period");
        wb_write(0, reg_addr(REGION_TIMER, TMR_CLEAR), 32'h0, 4'hf);
        check_value(32'd0, {31'd0, irq});
        wait_for_irq(1'b1, TMR_PERIOD + 10, seen);
        check_true(seen, "o_irq did not rise again after the flag was cleared");
        // Stop the timer and leave the controller masked
        wb_write(0, reg_addr(REGION_TIMER, TMR_CTRL), 32'h0, 4'hf);
        wb_write(0, reg_addr(REGION_TIMER, TMR_CLEAR), 32'h0, 4'hf);
        wb_write(0, reg_addr(REGION_IRQ, IRQ_ENABLE_CLR), 32'h1, 4'hf);
    endtask

    task automatic test_irq_mask();
        wb_data_t rdat;
        logic     seen;
        test_name = "test_irq_mask";
        wb_read(1, reg_addr(REGION_IRQ, IRQ_ENABLE_SET), rdat);
        check_value(32'h0, rdat);
        ext_int = 2'b01;
        for (int n = 0; n < 8; n++) begin
            @(posedge clk);
            #1;
            check_value(32'd0, {31'd0, irq});
        end
        wb_write(1, reg_addr(REGION_IRQ, IRQ_ENABLE_SET), 32'h2, 4'hf);
        wb_read(1, reg_addr(REGION_IRQ, IRQ_ENABLE_SET), rdat);
        check_value(32'h2, rdat);
        wait_for_irq(1'b1, 5, seen);
        check_true(seen, "o_irq did not rise with source 1 enabled");
        wb_write(1, reg_addr(REGION_IRQ, IRQ_ENABLE_CLR), 32'h2, 4'hf);
        wb_read(1, reg_addr(REGION_IRQ, IRQ_ENABLE_SET), rdat);
        check_value(32'h0, rdat);
        wait_for_irq(1'b0, 5, seen);
        check_true(seen, "o_irq did not fall after source 1 was masked");
        ext_int = 2'b00;
    endtask

    task automatic test_arbitration();
        wb_data_t d0;
        wb_data_t d1;
        wb_data_t rdat;
        test_name = "test_arbitration";
        rng = xorshift(rng);
        d0 = rng;
        rng = xorshift(rng);
        d1 = rng;
        done_at[0] = 0;
        done_at[1] = 0;
        fork
            wb_write(0, boot_addr(8'd2), d0, 4'hf);
            wb_write(1, boot_addr(8'd3), d1, 4'hf);
        join
        check_true(done_at[0] > 0 && done_at[1] > 0, "a master did not complete its write");
        check_true(done_at[0] < done_at[1], "master 0 did not complete before master 1");
        wb_read(1, boot_addr(8'd2), rdat);
        check_value(d0, rdat);
        wb_read(0, boot_addr(8'd3), rdat);
        check_value(d1, rdat);
    endtask

    // --------------------
    // Run control
    // --------------------
    initial begin
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
        end
        $display("Error: run stopped at the %0d cycle limit before the tests finished",
                 MAX_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        m0_req  = '0;
        m1_req  = '0;
        ext_int = 2'b00;
        rng     = 32'ha108;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        test_boot_mem();
        test_unmapped();
        test_timer_oneshot();
        test_timer_periodic();
        test_irq_mask();
        test_arbitration();
        $display("Tests finished with %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* build.f */
verilog/soc_pkg.sv
verilog/wb_arbiter.sv
verilog/wb_decoder.sv
verilog/boot_mem.sv
verilog/timer_module.sv
verilog/irq_controller.sv
verilog/periph_soc.sv
tb/tb_periph_soc.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_periph_soc
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^PASS: all tests$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
